//--- Bender.yml
package:
  name: exec_unit

sources:
  - include_dirs:
      - include
    files:
      - hdl/alu_pkg.sv
      - hdl/InstrDecoder.sv
      - hdl/RegFile.sv
      - hdl/Alu.sv
      - hdl/ResultStage.sv
      - hdl/ExecUnit.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/ExecUnitTb.sv

//--- build.f
+incdir+include
hdl/alu_pkg.sv
hdl/InstrDecoder.sv
hdl/RegFile.sv
hdl/Alu.sv
hdl/ResultStage.sv
hdl/ExecUnit.sv
tests/ExecUnitTb.sv

//--- hdl/Alu.sv
`include "alu_consts.svh"

module Alu (
	input  alu_pkg::aluCtrl_t         ctrl,
	input  logic [`DATA_WIDTH-1:0]    rdestData,
	input  logic [`DATA_WIDTH-1:0]    rsrcData,
	output logic [`DATA_WIDTH-1:0]    aluResult,
	output alu_pkg::flags_t           aluFlags,
	output logic [`FLAG_COUNT-1:0]    flagsUpdate
);

	logic [`DATA_WIDTH-1:0]   operand;
	logic [`DATA_WIDTH-1:0]   addB;
	logic [`DATA_WIDTH-1:0]   sum;
	logic                     carryIn;
	logic                     carryOut;
	logic                     isSub;
	logic [`DATA_WIDTH-1:0]   product;
	logic                     ltUnsigned;
	logic                     ltSigned;
	logic                     equal;
	logic                     overflow;

	// Second operand is the immediate for MOVI and ADDI.
	assign operand = ctrl.useImm ? ctrl.imm : rsrcData;

	// --------------------
	// Shared adder.

	// SUB is rdest + ~operand + 1.
	assign isSub   = (ctrl.opCode == `OP_SUB);
	assign addB    = isSub ? ~operand : operand;
	assign carryIn = isSub;

	assign {carryOut, sum} = {1'b0, rdestData} + {1'b0, addB} + {{`DATA_WIDTH{1'b0}}, carryIn};

	// Overflow when both adder inputs agree in sign and the sum does not.
	assign overflow = (rdestData[`DATA_WIDTH-1] & addB[`DATA_WIDTH-1] & ~sum[`DATA_WIDTH-1])
		| (~rdestData[`DATA_WIDTH-1] & ~addB[`DATA_WIDTH-1] & sum[`DATA_WIDTH-1]);

	// --------------------
	// Comparison.

	assign ltUnsigned = rdestData < operand;
	assign ltSigned   = $signed(rdestData) < $signed(operand);
	assign equal      = rdestData == operand;

	// Only the low half of the product is kept.
	assign product = rdestData * operand;

	// Flag values are always computed; the mask decides which ones land.
	always_comb begin
		aluFlags.c = carryOut;
		aluFlags.l = ltUnsigned;
		aluFlags.f = overflow;
		aluFlags.z = equal;
		aluFlags.n = ltSigned;
	end

	// --------------------
	// Result and flag mask select.

	always_comb begin
		aluResult   = rdestData;
		flagsUpdate = '0;
		case (ctrl.opCode)
			`OP_ADD, `OP_ADDI, `OP_SUB: begin
				aluResult   = sum;
				flagsUpdate = '1;
			end
			`OP_CMP: begin
				// C and F keep whatever the last add left.
				flagsUpdate[`FLAG_L] = 1'b1;
				flagsUpdate[`FLAG_Z] = 1'b1;
				flagsUpdate[`FLAG_N] = 1'b1;
			end
			`OP_MOVI: aluResult = operand;
			`OP_AND:  aluResult = rdestData & operand;
			`OP_OR:   aluResult = rdestData | operand;
			`OP_XOR:  aluResult = rdestData ^ operand;
			`OP_NOT:  aluResult = ~rdestData;
			`OP_LSH:  aluResult = rdestData << 1;
			`OP_RSH:  aluResult = rdestData >> 1;
			`OP_ARSH: aluResult = {rdestData[`DATA_WIDTH-1], rdestData[`DATA_WIDTH-1:1]};
			`OP_MUL:  aluResult = product;
			// NOP passes rdest through.
			default:  aluResult = rdestData;
		endcase
	end

endmodule

//--- hdl/ExecUnit.sv
`include "alu_consts.svh"

module ExecUnit (
	input  logic                   clk,
	input  logic                   rstN,
	input  logic                   instrValid,
	input  alu_pkg::instr_u        instr,
	output logic [`DATA_WIDTH-1:0] result,
	output alu_pkg::flags_t        flags,
	output logic                   resultValid
);

	logic [`REG_ADDR_WIDTH-1:0] rdestIdx;
	logic [`REG_ADDR_WIDTH-1:0] rsrcIdx;
	alu_pkg::aluCtrl_t          ctrl;
	logic [`DATA_WIDTH-1:0]     rdestData;
	logic [`DATA_WIDTH-1:0]     rsrcData;
	logic [`DATA_WIDTH-1:0]     aluResult;
	alu_pkg::flags_t            aluFlags;
	logic [`FLAG_COUNT-1:0]     flagsUpdate;

	InstrDecoder InstrDecoder_inst (
		.instrValid (instrValid),
		.instr      (instr),
		.rdestIdx   (rdestIdx),
		.rsrcIdx    (rsrcIdx),
		.ctrl       (ctrl)
	);

	// Write back goes to rdest at the strobe edge.
	RegFile RegFile_inst (
		.clk     (clk),
		.rstN    (rstN),
		.rdAddrA (rdestIdx),
		.rdAddrB (rsrcIdx),
		.rdDataA (rdestData),
		.rdDataB (rsrcData),
		.wrEn    (ctrl.writeEn),
		.wrAddr  (rdestIdx),
		.wrData  (aluResult)
	);

	Alu Alu_inst (
		.ctrl        (ctrl),
		.rdestData   (rdestData),
		.rsrcData    (rsrcData),
		.aluResult   (aluResult),
		.aluFlags    (aluFlags),
		.flagsUpdate (flagsUpdate)
	);

	ResultStage ResultStage_inst (
		.clk         (clk),
		.rstN        (rstN),
		.instrValid  (instrValid),
		.aluResult   (aluResult),
		.aluFlags    (aluFlags),
		.flagsUpdate (flagsUpdate),
		.result      (result),
		.flags       (flags),
		.resultValid (resultValid)
	);

endmodule

//--- hdl/InstrDecoder.sv
`include "alu_consts.svh"

module InstrDecoder (
	input  logic                       instrValid,
	input  alu_pkg::instr_u            instr,
	output logic [`REG_ADDR_WIDTH-1:0] rdestIdx,
	output logic [`REG_ADDR_WIDTH-1:0] rsrcIdx,
	output alu_pkg::aluCtrl_t          ctrl
);

	logic [`OP_WIDTH-1:0]   rawOp;
	logic [`OP_WIDTH-1:0]   opCode;
	logic                   isImm;
	logic                   writesBack;
	logic [`DATA_WIDTH-1:0] immExt;

	// The opcode sits in the same bits in both views.
	assign rawOp = instr.regForm.opCode;

	// Codes above ADDI are not assigned and run as NOP.
	always_comb begin
		if (rawOp > `OP_ADDI) begin
			opCode = `OP_NOP;
		end else begin
			opCode = rawOp;
		end
	end

	assign isImm = (opCode == `OP_MOVI) || (opCode == `OP_ADDI);

	// --------------------
	// Operand selection.

	// rdest sits in the same bits in both forms.
	assign rdestIdx = instr.regForm.rdest;

	// rsrc exists only in the register form.
	always_comb begin
		if (isImm) begin
			rsrcIdx = '0;
		end else begin
			rsrcIdx = instr.regForm.rsrc;
		end
	end

	// Sign extend the 8-bit immediate to a full word.
	assign immExt = {{(`DATA_WIDTH-`IMM_WIDTH){instr.immForm.imm[`IMM_WIDTH-1]}},
		instr.immForm.imm};

	// NOP and CMP leave the register file alone.
	assign writesBack = (opCode != `OP_NOP) && (opCode != `OP_CMP);

	// --------------------
	// Control word.

	always_comb begin
		ctrl.opCode  = opCode;
		ctrl.useImm  = isImm;
		ctrl.imm     = isImm ? immExt : '0;
		ctrl.writeEn = instrValid && writesBack;
	end

endmodule

//--- hdl/RegFile.sv
`include "alu_consts.svh"

module RegFile (
	input  logic                       clk,
	input  logic                       rstN,
	input  logic [`REG_ADDR_WIDTH-1:0] rdAddrA,
	input  logic [`REG_ADDR_WIDTH-1:0] rdAddrB,
	output logic [`DATA_WIDTH-1:0]     rdDataA,
	output logic [`DATA_WIDTH-1:0]     rdDataB,
	input  logic                       wrEn,
	input  logic [`REG_ADDR_WIDTH-1:0] wrAddr,
	input  logic [`DATA_WIDTH-1:0]     wrData
);

	logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

	// Write port. All registers start at zero.
	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn) begin
			regs[wrAddr] <= wrData;
		end
	end

	// --------------------
	// Read ports, combinational.

	// A following instruction sees the value written at the last edge.
	assign rdDataA = regs[rdAddrA];
	assign rdDataB = regs[rdAddrB];

endmodule

//--- hdl/ResultStage.sv
`include "alu_consts.svh"

module ResultStage (
	input  logic                    clk,
	input  logic                    rstN,
	input  logic                    instrValid,
	input  logic [`DATA_WIDTH-1:0]  aluResult,
	input  alu_pkg::flags_t         aluFlags,
	input  logic [`FLAG_COUNT-1:0]  flagsUpdate,
	output logic [`DATA_WIDTH-1:0]  result,
	output alu_pkg::flags_t         flags,
	output logic                    resultValid
);

	logic [`FLAG_COUNT-1:0] mergedFlags;

	// New bits where the mask is set, held bits elsewhere.
	assign mergedFlags = (flags & ~flagsUpdate) | (aluFlags & flagsUpdate);

	// --------------------
	// Output registers.

	always_ff @(posedge clk) begin
		if (!rstN) begin
			result      <= '0;
			flags       <= '0;
			resultValid <= 1'b0;
		end else begin
			// One pulse per strobe, NOP and CMP included.
			resultValid <= instrValid;
			if (instrValid) begin
				result <= aluResult;
				flags  <= alu_pkg::flags_t'(mergedFlags);
			end
		end
	end

endmodule

//--- hdl/alu_pkg.sv
`include "alu_consts.svh"

package alu_pkg;

	// --------------------
	// Instruction word views.

	// Register form: both operands come from the register file.
	typedef struct packed {
		logic [`OP_WIDTH-1:0]       opCode;
		logic [`REG_ADDR_WIDTH-1:0] rdest;
		logic [`REG_ADDR_WIDTH-1:0] rsrc;
		logic [3:0]                 unused;
	} instrReg_t;

	// Immediate form: the low byte replaces rsrc.
	typedef struct packed {
		logic [`OP_WIDTH-1:0]       opCode;
		logic [`REG_ADDR_WIDTH-1:0] rdest;
		logic [`IMM_WIDTH-1:0]      imm;
	} instrImm_t;

	// One 16-bit word, decoded either way.
	typedef union packed {
		instrReg_t regForm;
		instrImm_t immForm;
	} instr_u;

	// --------------------
	// Decoded control.

	typedef struct packed {
		logic [`OP_WIDTH-1:0]   opCode;
		logic                   useImm;
		logic [`DATA_WIDTH-1:0] imm;
		logic                   writeEn;
	} aluCtrl_t;

	// Condition flags, n in bit 4 down to c in bit 0.
	typedef struct packed {
		logic n;
		logic z;
		logic f;
		logic l;
		logic c;
	} flags_t;

endpackage

//--- include/alu_consts.svh
`ifndef ALU_CONSTS_SVH
`define ALU_CONSTS_SVH

// Datapath sizes.
`define DATA_WIDTH      16
`define REG_COUNT       16
`define REG_ADDR_WIDTH  4
`define OP_WIDTH        4
`define IMM_WIDTH       8

// --------------------
// Operation codes, reference encoding.
`define OP_NOP   4'd0
`define OP_SUB   4'd1
`define OP_CMP   4'd2
`define OP_AND   4'd3
`define OP_OR    4'd4
`define OP_XOR   4'd5
`define OP_NOT   4'd6
`define OP_LSH   4'd7
`define OP_RSH   4'd8
`define OP_ARSH  4'd9
`define OP_MUL   4'd10
`define OP_ADD   4'd11
// Immediate forms used to load the register file.
`define OP_MOVI  4'd12
`define OP_ADDI  4'd13

// --------------------
// Bit positions in the flag word.
`define FLAG_COUNT  5
`define FLAG_C      0
`define FLAG_L      1
`define FLAG_F      2
`define FLAG_Z      3
`define FLAG_N      4

`endif

//--- tests/ExecUnitTb.sv
`include "alu_consts.svh"

module ExecUnitTb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int ResetCycles   = 5;
	localparam int IdleCycles    = 4;
	localparam int TimeoutCycles = 10;

	logic                   clk;
	logic                   rstN;
	logic                   instrValid;
	alu_pkg::instr_u        instr;
	logic [`DATA_WIDTH-1:0] result;
	alu_pkg::flags_t        flags;
	logic                   resultValid;

	int vectorCount;
	int fd;

	ExecUnit ExecUnit_inst (
		.clk         (clk),
		.rstN        (rstN),
		.instrValid  (instrValid),
		.instr       (instr),
		.result      (result),
		.flags       (flags),
		.resultValid (resultValid)
	);

	// 20 ns clock period.
	always #10 clk = ~clk;

	// --------------------
	// Reporting.

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic compareValue(input string testName, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("CHECK FAILED %s: expected 0x%0h, actual 0x%0h", testName, expected,
				actual);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	// --------------------
	// Sequencing.

	task automatic applyReset();
		rstN = 1'b0;
		for (int i = 0; i < ResetCycles; i++) begin
			@(negedge clk);
		end
		rstN = 1'b1;
	endtask

	// Outputs stay cleared until the first strobe.
	task automatic checkIdleOutputs();
		for (int i = 0; i < IdleCycles; i++) begin
			@(negedge clk);
			compareValue($sformatf("idle cycle %0d resultValid", i), 32'd0, resultValid);
			compareValue($sformatf("idle cycle %0d result", i), 32'd0, result);
			compareValue($sformatf("idle cycle %0d flags", i), 32'd0, flags);
		end
	endtask

	// Returns on the falling edge where the pulse for the current strobe is visible.
	task automatic waitForResult(input string testName);
		int cycles;
		cycles = 1;
		@(negedge clk);
		instrValid = 1'b0;
		while (resultValid !== 1'b1) begin
			if (cycles >= TimeoutCycles) begin
				abortRun($sformatf("Timeout waiting for resultValid on %s", testName));
			end else begin
				@(negedge clk);
				cycles++;
			end
		end
	endtask

	// Each line: instruction, expected result, expected flags, check enable.
	task automatic runVectors(input int fileId);
		string                  line;
		string                  name;
		logic [`DATA_WIDTH-1:0] instrWord;
		logic [`DATA_WIDTH-1:0] expResult;
		logic [`FLAG_COUNT-1:0] expFlags;
		int                     checkOn;
		int                     fields;
		while ($fgets(line, fileId) != 0) begin
			if (line.len() < 2 || line.getc(0) == "#") begin
				// Comment or blank line.
			end else begin
				fields = $sscanf(line, "%h %h %h %d", instrWord, expResult, expFlags, checkOn);
				if (fields != 4) begin
					abortRun($sformatf("Malformed golden line: %s", line));
				end else begin
					vectorCount++;
					name = $sformatf("vector %0d (instr 0x%04h)", vectorCount, instrWord);
					// Back to back, the next word goes out on the same falling edge.
					instr      = alu_pkg::instr_u'(instrWord);
					instrValid = 1'b1;
					waitForResult(name);
					if (checkOn != 0) begin
						compareValue({name, " result"}, expResult, result);
						compareValue({name, " flags"}, expFlags, flags);
					end
				end
			end
		end
	endtask

	// resultValid must drop one cycle after the last strobe.
	task automatic checkPulseEnd();
		@(negedge clk);
		compareValue("resultValid after last strobe", 32'd0, resultValid);
		if (vectorCount == 0) begin
			abortRun("No vectors were read from the golden file");
		end
	endtask

	// --------------------
	// Main sequence.

	initial begin
		clk         = 1'b0;
		rstN        = 1'b0;
		instrValid  = 1'b0;
		instr       = '0;
		vectorCount = 0;

		applyReset();
		checkIdleOutputs();

		fd = $fopen("tests/exec_golden.txt", "r");
		if (fd == 0) begin
			abortRun("Cannot open tests/exec_golden.txt");
		end else begin
			runVectors(fd);
			$fclose(fd);
			checkPulseEnd();
			$display("%0d vectors applied", vectorCount);
			$display("Test completed successfully");
			$finish;
		end
	end

endmodule

//--- tests/exec_golden.txt
# instr result flags check, all hex except check (1 = compare result and flags)
# flags bits: n z f l c, c in bit 0
# MOVI each register with a sign-extended immediate
C07F 007F 00 1 movi r0
C1FF FFFF 00 1 movi r1
C201 0001 00 1 movi r2
C380 FF80 00 1 movi r3
C405 0005 00 1 movi r4
C5FE FFFE 00 1 movi r5
C610 0010 00 1 movi r6
C700 0000 00 1 movi r7
C8A5 FFA5 00 1 movi r8
C93C 003C 00 1 movi r9
CAC3 FFC3 00 1 movi r10
CB07 0007 00 1 movi r11
CC90 FF90 00 1 movi r12
CD55 0055 00 1 movi r13
CEF0 FFF0 00 1 movi r14
CF22 0022 00 1 movi r15
# NOP reads back every register
0000 007F 00 1 nop r0
0100 FFFF 00 1 nop r1
0200 0001 00 1 nop r2
0300 FF80 00 1 nop r3
0400 0005 00 1 nop r4
0500 FFFE 00 1 nop r5
0600 0010 00 1 nop r6
0700 0000 00 1 nop r7
0800 FFA5 00 1 nop r8
0900 003C 00 1 nop r9
0A00 FFC3 00 1 nop r10
0B00 0007 00 1 nop r11
0C00 FF90 00 1 nop r12
0D00 0055 00 1 nop r13
0E00 FFF0 00 1 nop r14
0F00 0022 00 1 nop r15
# ADD, ADDI and SUB with all five flags
D101 0000 11 1 addi r1 +1 carry out
8500 7FFF 11 1 rsh r5 builds 0x7fff
D501 8000 04 1 addi r5 +1 signed overflow
B420 0006 00 1 add r4 r2
1230 0081 02 1 sub r2 r3 unsigned less only
1660 0000 09 1 sub r6 r6 equal
1340 FF7A 11 1 sub r3 r4 signed less only
1050 807F 06 1 sub r0 r5 overflow
D9F0 002C 03 1 addi r9 -16
B550 0000 0D 1 add r5 r5 carry and overflow
# CMP keeps C and F and writes nothing
2BD0 0007 17 1 cmp r11 r13
2840 FFA5 15 1 cmp r8 r4
2FF0 0022 0D 1 cmp r15 r15
22C0 0081 07 1 cmp r2 r12
0B00 0007 07 1 nop r11 unchanged
0800 FFA5 07 1 nop r8 unchanged
# Logic, shift and multiply leave the flags alone
3A80 FF81 07 1 and r10 r8
4CD0 FFD5 07 1 or r12 r13
5E80 0055 07 1 xor r14 r8
6300 0085 07 1 not r3
7800 FF4A 07 1 lsh r8
8A00 7FC0 07 1 rsh r10
9C00 FFEA 07 1 arsh r12
A0B0 8379 07 1 mul r0 r11
ACE0 F8B2 07 1 mul r12 r14
# Chained results on r7, then unused opcodes
D703 0003 12 1 addi r7 +3
B770 0006 08 1 add r7 r7
A770 0024 08 1 mul r7 r7
1740 001E 01 1 sub r7 r4
7700 003C 01 1 lsh r7
E712 003C 01 1 opcode 14 as nop
F7FF 003C 01 1 opcode 15 as nop
0700 003C 01 1 nop r7 unchanged
B790 0068 00 1 add r7 r9
